// File: dv/execute_port2_assert.sv
`timescale 1ns/10ps
`include "exe_alu2_cfg.svh"

module execute_port2_assert (
	input logic iCLOCK,
	input logic inRESET,
	input logic free,
	input logic in_valid,
	input logic in_writeback,
	input logic [`EXE_TAG_W-1:0] in_commit_tag,
	input logic [`EXE_CMD_W-1:0] cmd,
	input logic sel_sysreg,
	input logic sel_logic,
	input logic sel_shift,
	input logic [`EXE_DATA_W-1:0] source0,
	input logic [`EXE_DATA_W-1:0] source1,
	input logic dest_sysreg,
	input logic [`EXE_REGNAME_W-1:0] dest_regname,
	input logic flags_writeback,
	input logic [`EXE_FLAGREG_W-1:0] flags_regname,
	input logic wb_valid,
	input logic [`EXE_TAG_W-1:0] wb_commit_tag,
	input logic wb_sysreg,
	input logic [`EXE_REGNAME_W-1:0] wb_regname,
	input logic wb_writeback,
	input logic [`EXE_DATA_W-1:0] wb_data,
	input exe_alu2_pkg::alu_flags_t wb_flags,
	input logic wb_flags_writeback,
	input logic [`EXE_FLAGREG_W-1:0] wb_flags_regname
);
	localparam int DW = `EXE_DATA_W;

	int fail_count = 0;
	logic [DW:0] signed_wide;
	logic add_carry;
	logic [DW-1:0] sysreg_ref;
	logic wb_all_zero;

	// Overflow shows as bits DW and DW-1 of the sign-extended result disagreeing
	always_comb begin
		if (cmd == exe_alu2_pkg::SUB) begin
			signed_wide = {source0[DW-1], source0} - {source1[DW-1], source1};
			add_carry = (source0 < source1);
		end else begin
			signed_wide = {source0[DW-1], source0} + {source1[DW-1], source1};
			add_carry = ((source0 + source1) < source0);
		end
	end

	assign sysreg_ref = (cmd == exe_alu2_pkg::WRITE) ? source1 : source0;

	assign wb_all_zero = !wb_valid && wb_commit_tag == '0 && !wb_sysreg &&
		wb_regname == '0 && !wb_writeback && wb_data == '0 && wb_flags == '0 &&
		!wb_flags_writeback && wb_flags_regname == '0;

	a_latency: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$past(inRESET) && !$past(free) |->
			wb_valid == $past(in_valid) && wb_commit_tag == $past(in_commit_tag) &&
			wb_sysreg == $past(dest_sysreg) && wb_regname == $past(dest_regname) &&
			wb_writeback == $past(in_writeback) &&
			wb_flags_writeback == $past(flags_writeback) &&
			wb_flags_regname == $past(flags_regname))
	else begin
		fail_count++;
		$error("writeback fields do not follow the operation of the previous cycle");
	end

	a_flush: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$past(inRESET) && $past(free) |-> wb_all_zero)
	else begin
		fail_count++;
		$error("free did not clear the writeback buffer");
	end

	// First edge after reset release sees the buffer as reset left it
	a_reset: assert property (@(posedge iCLOCK) $rose(inRESET) |-> wb_all_zero)
	else begin
		fail_count++;
		$error("writeback outputs not zero after reset");
	end

	// Adder is the fallback when no select is set
	a_adder: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$past(inRESET && !free && !sel_sysreg && !sel_logic && !sel_shift) |->
			wb_data == $past(signed_wide[DW-1:0]) && wb_flags.cf == $past(add_carry) &&
			wb_flags.of == $past(signed_wide[DW] ^ signed_wide[DW-1]))
	else begin
		fail_count++;
		$error("adder result, carry or overflow is wrong");
	end

	a_flags: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		wb_valid && !$past(sel_sysreg) |->
			wb_flags.sf == wb_data[DW-1] && wb_flags.zf == (wb_data == '0) &&
			wb_flags.pf == ~^wb_data[7:0])
	else begin
		fail_count++;
		$error("sign, zero or parity flag does not match the result");
	end

	a_sysreg: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$past(inRESET && !free && sel_sysreg) |->
			wb_data == $past(sysreg_ref) && wb_flags == '0)
	else begin
		fail_count++;
		$error("system register path did not win the select or left flags set");
	end

endmodule

// File: dv/execute_port2_tb.sv
`timescale 1ns/10ps
`include "exe_alu2_cfg.svh"

module execute_port2_tb;
	localparam int DW = `EXE_DATA_W;
	localparam int WAIT_LIMIT = 16;

	logic iCLOCK;
	logic inRESET;
	logic free;
	logic in_valid;
	logic in_writeback;
	logic [`EXE_TAG_W-1:0] in_commit_tag;
	logic [`EXE_CMD_W-1:0] cmd;
	logic sel_sysreg;
	logic sel_logic;
	logic sel_shift;
	logic [DW-1:0] source0;
	logic [DW-1:0] source1;
	logic dest_sysreg;
	logic [`EXE_REGNAME_W-1:0] dest_regname;
	logic flags_writeback;
	logic [`EXE_FLAGREG_W-1:0] flags_regname;
	logic wb_valid;
	logic [`EXE_TAG_W-1:0] wb_commit_tag;
	logic wb_sysreg;
	logic [`EXE_REGNAME_W-1:0] wb_regname;
	logic wb_writeback;
	logic [DW-1:0] wb_data;
	exe_alu2_pkg::alu_flags_t wb_flags;
	logic wb_flags_writeback;
	logic [`EXE_FLAGREG_W-1:0] wb_flags_regname;

	integer seed;
	int err_count;

	execute_port2 uut (.*);

	bind execute_port2 execute_port2_assert u_assert (.*);

	always #4 iCLOCK = ~iCLOCK;

	// Logic unit model
	function automatic logic [DW-1:0] logic_result(
		input logic [4:0] c,
		input logic [DW-1:0] a,
		input logic [DW-1:0] b
	);
		logic [DW-1:0] r;
		case (c)
			exe_alu2_pkg::BUF1: r = b;
			exe_alu2_pkg::AND: r = a & b;
			exe_alu2_pkg::OR: r = a | b;
			exe_alu2_pkg::XOR: r = a ^ b;
			exe_alu2_pkg::NOT: r = ~a;
			exe_alu2_pkg::NAND: r = ~(a & b);
			exe_alu2_pkg::NOR: r = ~(a | b);
			exe_alu2_pkg::XNOR: r = ~(a ^ b);
			exe_alu2_pkg::CLB: r = a & ~(32'd1 << b[4:0]);
			exe_alu2_pkg::STB: r = a | (32'd1 << b[4:0]);
			exe_alu2_pkg::BITREV: begin
				for (int i = 0; i < DW; i++) begin
					r[i] = a[DW-1-i];
				end
			end
			exe_alu2_pkg::BYTEREV: r = {a[7:0], a[15:8], a[23:16], a[31:24]};
			exe_alu2_pkg::GETBIT: r = {31'd0, a[b[4:0]]};
			exe_alu2_pkg::GETBYTE: r = (a >> (8 * b[1:0])) & 32'hff;
			exe_alu2_pkg::LIL: r = {a[31:16], b[15:0]};
			exe_alu2_pkg::LIH: r = {b[15:0], a[15:0]};
			default: r = a;
		endcase
		return r;
	endfunction

	// Shift unit model with the carry in the top bit
	function automatic logic [DW:0] shift_result(
		input logic [4:0] c,
		input logic [DW-1:0] a,
		input logic [DW-1:0] b
	);
		logic [4:0] n;
		logic [2*DW-1:0] twice;
		logic [DW-1:0] r;
		logic cy;
		n = b[4:0];
		twice = {a, a};
		cy = 1'b0;
		case (c)
			exe_alu2_pkg::LSL, exe_alu2_pkg::ROL: begin
				r = (c == exe_alu2_pkg::LSL) ? (a << n) : ((twice << n) >> DW);
				if (n != 0) cy = a[DW-n];
			end
			exe_alu2_pkg::LSR, exe_alu2_pkg::ASR, exe_alu2_pkg::ROR: begin
				if (c == exe_alu2_pkg::LSR) r = a >> n;
				else if (c == exe_alu2_pkg::ASR) r = $signed(a) >>> n;
				else r = twice >> n;
				if (n != 0) cy = a[n-1];
			end
			default: r = a;
		endcase
		return {cy, r};
	endfunction

	task automatic check_result(input string name, input logic [DW-1:0] exp_data,
		input logic exp_cf);
		exe_alu2_pkg::alu_flags_t exp_flags;
		exp_flags.sf = exp_data[DW-1];
		exp_flags.of = 1'b0;
		exp_flags.cf = exp_cf;
		exp_flags.pf = ~^exp_data[7:0];
		exp_flags.zf = (exp_data == '0);
		if (wb_data !== exp_data || wb_flags !== exp_flags) begin
			err_count++;
			$display("ERR %s: expected data %h flags %b, actual data %h flags %b",
				name, exp_data, exp_flags, wb_data, wb_flags);
		end
	endtask

	// One cycle of unconstrained traffic with an occasional free
	task automatic drive_random();
		@(posedge iCLOCK);
		free <= (($random(seed) & 15) == 0);
		in_valid <= $random(seed);
		in_writeback <= $random(seed);
		in_commit_tag <= $random(seed);
		cmd <= $random(seed);
		{sel_sysreg, sel_logic, sel_shift} <= $random(seed);
		source0 <= $random(seed);
		source1 <= $random(seed);
		dest_sysreg <= $random(seed);
		dest_regname <= $random(seed);
		flags_writeback <= $random(seed);
		flags_regname <= $random(seed);
	endtask

	// Issue one operation and wait for it to reach writeback
	task automatic run_op(input string name, input logic [2:0] sels, input logic [4:0] c,
		input logic [DW-1:0] a, input logic [DW-1:0] b);
		int waited;
		@(posedge iCLOCK);
		free <= 1'b0;
		in_valid <= 1'b1;
		{sel_sysreg, sel_logic, sel_shift} <= sels;
		cmd <= c;
		source0 <= a;
		source1 <= b;
		in_commit_tag <= $random(seed);
		dest_regname <= $random(seed);
		@(posedge iCLOCK);
		in_valid <= 1'b0;
		waited = 0;
		@(negedge iCLOCK);
		while (!wb_valid && waited < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			waited++;
		end
		if (!wb_valid) begin
			err_count++;
			$display("Timeout: no writeback seen for %s", name);
		end
	endtask

	initial begin
		logic [DW-1:0] a;
		logic [DW-1:0] b;
		logic [DW:0] expect_shift;
		logic [4:0] c;
		seed = 58;
		err_count = 0;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		free = 1'b0;
		in_valid = 1'b0;
		in_writeback = 1'b0;
		in_commit_tag = '0;
		cmd = '0;
		sel_sysreg = 1'b0;
		sel_logic = 1'b0;
		sel_shift = 1'b0;
		source0 = '0;
		source1 = '0;
		dest_sysreg = 1'b0;
		dest_regname = '0;
		flags_writeback = 1'b0;
		flags_regname = '0;
		repeat (3) @(posedge iCLOCK);
		inRESET <= 1'b1;

		repeat (300) drive_random();

		// Shift select also set on odd passes, logic has to win
		for (int i = 0; i < 60; i++) begin
			a = $random(seed);
			b = $random(seed);
			c = $unsigned($random(seed)) % 20;
			run_op("logic", {2'b01, i[0]}, c, a, b);
			check_result("logic", logic_result(c, a, b), 1'b0);
		end
		for (int i = 0; i < 60; i++) begin
			a = $random(seed);
			b = $random(seed);
			c = $unsigned($random(seed)) % 8;
			run_op("shift", 3'b001, c, a, b);
			expect_shift = shift_result(c, a, b);
			check_result("shift", expect_shift[DW-1:0], expect_shift[DW]);
		end

		// Adder corner cases
		run_op("add overflow", 3'b000, exe_alu2_pkg::ADD, 32'h7fff_ffff, 32'h1);
		run_op("add carry", 3'b000, exe_alu2_pkg::ADD, 32'hffff_ffff, 32'h1);
		run_op("sub borrow", 3'b000, exe_alu2_pkg::SUB, 32'h0, 32'h1);
		run_op("sub overflow", 3'b000, exe_alu2_pkg::SUB, 32'h8000_0000, 32'h1);

		// Sysreg wins over the other selects
		run_op("sysreg write", 3'b111, exe_alu2_pkg::WRITE, 32'h0000_0001, 32'h8000_0000);
		run_op("sysreg read", 3'b110, exe_alu2_pkg::READ, 32'hdead_beef, 32'h0);

		@(posedge iCLOCK);
		in_valid <= 1'b1;
		free <= 1'b1;
		@(posedge iCLOCK);
		in_valid <= 1'b0;
		free <= 1'b0;
		repeat (2) @(posedge iCLOCK);
		@(negedge iCLOCK);

		$display("Errors: %0d reference, %0d assertion", err_count,
			uut.u_assert.fail_count);
		if (err_count == 0 && uut.u_assert.fail_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: exe_alu2.f
+incdir+hw
hw/exe_alu2_pkg.sv
hw/alu_unit_if.sv
hw/exe_logic.sv
hw/exe_shift.sv
hw/exe_adder.sv
hw/execute_port2.sv
dv/execute_port2_assert.sv
dv/execute_port2_tb.sv

// File: hw/alu_unit_if.sv
`timescale 1ns/10ps
`include "exe_alu2_cfg.svh"

interface alu_unit_if;
	// Operands and command from the port
	logic [`EXE_DATA_W-1:0] source0;
	logic [`EXE_DATA_W-1:0] source1;
	logic [`EXE_CMD_W-1:0] cmd;

	// Result back from the unit
	logic [`EXE_DATA_W-1:0] data;
	exe_alu2_pkg::alu_flags_t flags;

	modport unit (
		input source0,
		input source1,
		input cmd,
		output data,
		output flags
	);

	modport port (
		output source0,
		output source1,
		output cmd,
		input data,
		input flags
	);
endinterface

// File: hw/exe_adder.sv
`timescale 1ns/10ps
`include "exe_alu2_cfg.svh"

module exe_adder (
	alu_unit_if.unit op
);
	localparam int DW = `EXE_DATA_W;

	logic [DW:0] sum;
	logic [DW:0] diff;
	logic [DW-1:0] result;
	logic is_sub;
	logic carry;
	logic overflow;

	// Unknown codes fall back to ADD
	assign is_sub = (exe_alu2_pkg::adder_cmd_e'(op.cmd) == exe_alu2_pkg::SUB);

	assign sum = {1'b0, op.source0} + {1'b0, op.source1};
	assign diff = {1'b0, op.source0} - {1'b0, op.source1};

	// Top bit of diff is the borrow
	assign result = is_sub ? diff[DW-1:0] : sum[DW-1:0];
	assign carry = is_sub ? diff[DW] : sum[DW];

	// Signed overflow from operand and result signs
	assign overflow = is_sub ?
		((op.source0[DW-1] != op.source1[DW-1]) && (result[DW-1] != op.source0[DW-1])) :
		((op.source0[DW-1] == op.source1[DW-1]) && (result[DW-1] != op.source0[DW-1]));

	assign op.data = result;
	assign op.flags = '{
		sf: result[DW-1],
		of: overflow,
		cf: carry,
		pf: exe_alu2_pkg::parity_even(result),
		zf: exe_alu2_pkg::is_zero(result)
	};

endmodule

// File: hw/exe_alu2_cfg.svh
`ifndef EXE_ALU2_CFG_SVH
`define EXE_ALU2_CFG_SVH

// Operand and result width
`define EXE_DATA_W 32

// Commit tag handed back to the scheduler
`define EXE_TAG_W 6

// Destination register names
`define EXE_REGNAME_W 6
`define EXE_FLAGREG_W 4

// Issued command and shift amount
`define EXE_CMD_W 5
`define EXE_SHAMT_W 5

`endif

// File: hw/exe_alu2_pkg.sv
`include "exe_alu2_cfg.svh"

package exe_alu2_pkg;

	// Condition flags, packed in writeback order
	typedef struct packed {
		logic sf;
		logic of;
		logic cf;
		logic pf;
		logic zf;
	} alu_flags_t;

	typedef enum logic [`EXE_CMD_W-1:0] {
		BUF0    = 5'h00,
		BUF1    = 5'h01,
		AND     = 5'h02,
		OR      = 5'h03,
		XOR     = 5'h04,
		NOT     = 5'h05,
		NAND    = 5'h06,
		NOR     = 5'h07,
		XNOR    = 5'h08,
		CLB     = 5'h09,
		STB     = 5'h0a,
		BITREV  = 5'h0b,
		BYTEREV = 5'h0c,
		GETBIT  = 5'h0d,
		GETBYTE = 5'h0e,
		LIL     = 5'h0f,
		LIH     = 5'h10
	} logic_cmd_e;

	typedef enum logic [`EXE_CMD_W-1:0] {
		BUFFER = 5'h00,
		LSL    = 5'h01,
		LSR    = 5'h02,
		ASR    = 5'h03,
		ROL    = 5'h04,
		ROR    = 5'h05
	} shift_cmd_e;

	typedef enum logic [`EXE_CMD_W-1:0] {
		ADD = 5'h00,
		SUB = 5'h01
	} adder_cmd_e;

	typedef enum logic [`EXE_CMD_W-1:0] {
		READ  = 5'h00,
		WRITE = 5'h01
	} sysreg_cmd_e;

	// Parity flag looks at the low byte only
	function automatic logic parity_even(input logic [`EXE_DATA_W-1:0] value);
		return ~^value[7:0];
	endfunction

	function automatic logic is_zero(input logic [`EXE_DATA_W-1:0] value);
		return (value == '0);
	endfunction

endpackage

// File: hw/exe_logic.sv
`timescale 1ns/10ps
`include "exe_alu2_cfg.svh"

module exe_logic (
	alu_unit_if.unit op
);
	localparam int DW = `EXE_DATA_W;
	localparam int NBYTES = DW / 8;
	localparam int HALF = DW / 2;

	logic [DW-1:0] result;
	logic [DW-1:0] bit_mask;
	logic [DW-1:0] bit_rev;
	logic [DW-1:0] byte_rev;
	logic [`EXE_SHAMT_W-1:0] bit_pos;
	logic [1:0] byte_pos;

	assign bit_pos = op.source1[`EXE_SHAMT_W-1:0];
	assign byte_pos = op.source1[1:0];
	assign bit_mask = {{(DW-1){1'b0}}, 1'b1} << bit_pos;

	// Bit and byte reversal of source0
	always_comb begin
		for (int i = 0; i < DW; i++) begin
			bit_rev[i] = op.source0[DW-1-i];
		end
		for (int j = 0; j < NBYTES; j++) begin
			byte_rev[j*8 +: 8] = op.source0[(NBYTES-1-j)*8 +: 8];
		end
	end

	always_comb begin
		case (exe_alu2_pkg::logic_cmd_e'(op.cmd))
			exe_alu2_pkg::BUF1:    result = op.source1;
			exe_alu2_pkg::AND:     result = op.source0 & op.source1;
			exe_alu2_pkg::OR:      result = op.source0 | op.source1;
			exe_alu2_pkg::XOR:     result = op.source0 ^ op.source1;
			exe_alu2_pkg::NOT:     result = ~op.source0;
			exe_alu2_pkg::NAND:    result = ~(op.source0 & op.source1);
			exe_alu2_pkg::NOR:     result = ~(op.source0 | op.source1);
			exe_alu2_pkg::XNOR:    result = ~(op.source0 ^ op.source1);
			exe_alu2_pkg::CLB:     result = op.source0 & ~bit_mask;
			exe_alu2_pkg::STB:     result = op.source0 | bit_mask;
			exe_alu2_pkg::BITREV:  result = bit_rev;
			exe_alu2_pkg::BYTEREV: result = byte_rev;
			exe_alu2_pkg::GETBIT: begin
				result = {{(DW-1){1'b0}}, op.source0[bit_pos]};
			end
			exe_alu2_pkg::GETBYTE: begin
				result = {{(DW-8){1'b0}}, op.source0[byte_pos*8 +: 8]};
			end
			// Immediate sits in the low half of source1
			exe_alu2_pkg::LIL: begin
				result = {op.source0[DW-1:HALF], op.source1[HALF-1:0]};
			end
			exe_alu2_pkg::LIH: begin
				result = {op.source1[HALF-1:0], op.source0[HALF-1:0]};
			end
			// BUF0 and unknown codes pass source0
			default: result = op.source0;
		endcase
	end

	assign op.data = result;

	// No carry or overflow from logic operations
	assign op.flags = '{
		sf: result[DW-1],
		of: 1'b0,
		cf: 1'b0,
		pf: exe_alu2_pkg::parity_even(result),
		zf: exe_alu2_pkg::is_zero(result)
	};

endmodule

// File: hw/exe_shift.sv
`timescale 1ns/10ps
`include "exe_alu2_cfg.svh"

module exe_shift (
	alu_unit_if.unit op
);
	localparam int DW = `EXE_DATA_W;

	logic [`EXE_SHAMT_W-1:0] amount;
	logic [DW-1:0] result;
	logic [DW-1:0] rol_data;
	logic [DW-1:0] ror_data;
	logic carry;

	assign amount = op.source1[`EXE_SHAMT_W-1:0];

	// A zero amount shifts by the full width on the wrap side, which yields zero
	assign rol_data = (op.source0 << amount) | (op.source0 >> (DW - amount));
	assign ror_data = (op.source0 >> amount) | (op.source0 << (DW - amount));

	// Extra bit beside the operand catches the last bit shifted out
	always_comb begin
		case (exe_alu2_pkg::shift_cmd_e'(op.cmd))
			exe_alu2_pkg::LSL: begin
				{carry, result} = {1'b0, op.source0} << amount;
			end
			exe_alu2_pkg::LSR: begin
				{result, carry} = {op.source0, 1'b0} >> amount;
			end
			exe_alu2_pkg::ASR: begin
				{result, carry} = $signed({op.source0, 1'b0}) >>> amount;
			end
			exe_alu2_pkg::ROL: begin
				result = rol_data;
				carry = (amount != '0) & rol_data[0];
			end
			exe_alu2_pkg::ROR: begin
				result = ror_data;
				carry = (amount != '0) & ror_data[DW-1];
			end
			// BUFFER and unknown codes
			default: begin
				result = op.source0;
				carry = 1'b0;
			end
		endcase
	end

	assign op.data = result;
	assign op.flags = '{
		sf: result[DW-1],
		of: 1'b0,
		cf: carry,
		pf: exe_alu2_pkg::parity_even(result),
		zf: exe_alu2_pkg::is_zero(result)
	};

endmodule

// File: hw/execute_port2.sv
`timescale 1ns/10ps
`include "exe_alu2_cfg.svh"

module execute_port2 (
	input logic iCLOCK,
	input logic inRESET,
	input logic free,
	input logic in_valid,
	input logic in_writeback,
	input logic [`EXE_TAG_W-1:0] in_commit_tag,
	input logic [`EXE_CMD_W-1:0] cmd,
	input logic sel_sysreg,
	input logic sel_logic,
	input logic sel_shift,
	input logic [`EXE_DATA_W-1:0] source0,
	input logic [`EXE_DATA_W-1:0] source1,
	input logic dest_sysreg,
	input logic [`EXE_REGNAME_W-1:0] dest_regname,
	input logic flags_writeback,
	input logic [`EXE_FLAGREG_W-1:0] flags_regname,
	output logic wb_valid,
	output logic [`EXE_TAG_W-1:0] wb_commit_tag,
	output logic wb_sysreg,
	output logic [`EXE_REGNAME_W-1:0] wb_regname,
	output logic wb_writeback,
	output logic [`EXE_DATA_W-1:0] wb_data,
	output exe_alu2_pkg::alu_flags_t wb_flags,
	output logic wb_flags_writeback,
	output logic [`EXE_FLAGREG_W-1:0] wb_flags_regname
);
	alu_unit_if logic_bus ();
	alu_unit_if shift_bus ();
	alu_unit_if adder_bus ();

	logic [`EXE_DATA_W-1:0] sysreg_data;
	logic [`EXE_DATA_W-1:0] sel_data;
	exe_alu2_pkg::alu_flags_t sel_flags;

	// Every unit sees the same issued operation
	assign logic_bus.source0 = source0;
	assign logic_bus.source1 = source1;
	assign logic_bus.cmd = cmd;
	assign shift_bus.source0 = source0;
	assign shift_bus.source1 = source1;
	assign shift_bus.cmd = cmd;
	assign adder_bus.source0 = source0;
	assign adder_bus.source1 = source1;
	assign adder_bus.cmd = cmd;

	exe_logic u_logic (.op(logic_bus.unit));
	exe_shift u_shift (.op(shift_bus.unit));
	exe_adder u_adder (.op(adder_bus.unit));

	// System register path, unknown codes read
	assign sysreg_data = (exe_alu2_pkg::sysreg_cmd_e'(cmd) == exe_alu2_pkg::WRITE) ?
		source1 : source0;

	// Unit select, sysreg has highest priority and the adder is the fallback
	always_comb begin
		if (sel_sysreg) begin
			sel_data = sysreg_data;
			sel_flags = '0;
		end else if (sel_logic) begin
			sel_data = logic_bus.data;
			sel_flags = logic_bus.flags;
		end else if (sel_shift) begin
			sel_data = shift_bus.data;
			sel_flags = shift_bus.flags;
		end else begin
			sel_data = adder_bus.data;
			sel_flags = adder_bus.flags;
		end
	end

	// One-entry writeback buffer
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wb_valid <= 1'b0;
			wb_commit_tag <= '0;
			wb_sysreg <= 1'b0;
			wb_regname <= '0;
			wb_writeback <= 1'b0;
			wb_data <= '0;
			wb_flags <= '0;
			wb_flags_writeback <= 1'b0;
			wb_flags_regname <= '0;
		end else if (free) begin
			// Flush empties the entry
			wb_valid <= 1'b0;
			wb_commit_tag <= '0;
			wb_sysreg <= 1'b0;
			wb_regname <= '0;
			wb_writeback <= 1'b0;
			wb_data <= '0;
			wb_flags <= '0;
			wb_flags_writeback <= 1'b0;
			wb_flags_regname <= '0;
		end else begin
			wb_valid <= in_valid;
			wb_commit_tag <= in_commit_tag;
			wb_sysreg <= dest_sysreg;
			wb_regname <= dest_regname;
			wb_writeback <= in_writeback;
			wb_data <= sel_data;
			wb_flags <= sel_flags;
			wb_flags_writeback <= flags_writeback;
			wb_flags_regname <= flags_regname;
		end
	end

endmodule
